// ==== tb_input.txt ====
// Test count, then per test: op(1=write) size addr sub mask data expected_read
d
1 2 0001 0 FFFF 88888888_77777777_66666666_55555555_44444444_33333333_22222222_11111111 0
0 2 0001 0 0 0 88888888_77777777_66666666_55555555_44444444_33333333_22222222_11111111
1 1 0002 0 000F EEEEEEEE_EEEEEEEE_EEEEEEEE_EEEEEEEE_EEEEEEEE_EEEEEEEE_DEADBEEF_CAFEBABE 0
0 1 0002 0 0 0 DEADBEEF_CAFEBABE
1 0 0003 5 0002 99999999_12345678 0
0 0 0003 5 0 0 1234001D
1 2 0004 0 5AC3 B7B7B7B7_B6B6B6B6_B5B5B5B5_B4B4B4B4_B3B3B3B3_B2B2B2B2_B1B1B1B1_B0B0B0B0 0
0 2 0004 0 0 0 A5A5B7B7_A5A5B6B6_B5B50025_B4B40024_B3B3B3B3_A5A50022_A5A50021_B0B0B0B0
0 0 0010 3 0 0 A5A50083
1 0 0010 3 FFFF 0F0F0F0F 0
0 1 0010 2 0 0 0F0F0F0F_A5A50082
1 3 0005 0 FFFF C7C7C7C7_C6C6C6C6_C5C5C5C5_C4C4C4C4_C3C3C3C3_C2C2C2C2_C1C1C1C1_C0C0C0C0 0
0 3 0005 0 0 0 C7C7C7C7_C6C6C6C6_C5C5C5C5_C4C4C4C4_C3C3C3C3_C2C2C2C2_C1C1C1C1_C0C0C0C0

// ==== list.f ====
+incdir+.
ddrBridgePkg.sv
burstCtrlIf.sv
burstController.sv
writeSerializer.sv
readAssembler.sv
psxDdrBridge.sv
tbClockGen.sv
tbMemModel.sv
tbChecker.sv
tbPsxDdrBridge.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tbPsxDdrBridge -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" sim.log; then
  exit 0
else
  exit 1
fi

// ==== tbPsxDdrBridge.sv ====
`timescale 1ns/1ps

module tbPsxDdrBridge;

  logic         clk;
  logic         rst;
  logic         command = 1'b0;
  logic         writeElseRead = 1'b0;
  logic [1:0]   commandSize = '0;
  logic [14:0]  targetAddr = '0;
  logic [2:0]   subAddr = '0;
  logic [15:0]  writeMask = '0;
  logic [255:0] dataClient = '0;
  logic         busyClient;
  logic         dataValidClient;
  logic [255:0] dataToClient;
  logic         busyMem;
  logic         dataValidMem;
  logic [31:0]  dataFromMem;
  logic         writeEnableMem;
  logic         readEnableMem;
  logic [7:0]   burstLength;
  logic [31:0]  dataToMem;
  logic [25:0]  memAddr;
  logic [3:0]   byteEnableMem;

  logic         expWrite = 1'b0;
  logic [1:0]   expSize = '0;
  logic [25:0]  expAddr = '0;
  logic [15:0]  expMask = '0;
  logic [255:0] expData = '0;
  logic [255:0] expRead = '0;
  logic [255:0] vec [0:127];
  int           numTests = 0;
  int           testsDone;
  int           errors;
  int           base;

  tbClockGen clockGen_inst (.o_clk(clk), .o_rst(rst));

  psxDdrBridge psxDdrBridge_inst (
    .i_clk(clk), .i_rst(rst),
    .i_command(command), .i_writeElseRead(writeElseRead),
    .i_commandSize(commandSize), .i_targetAddr(targetAddr), .i_subAddr(subAddr),
    .i_writeMask(writeMask), .i_dataClient(dataClient),
    .o_busyClient(busyClient), .o_dataValidClient(dataValidClient),
    .o_dataClient(dataToClient),
    .i_busyMem(busyMem), .i_dataValidMem(dataValidMem), .i_dataMem(dataFromMem),
    .o_writeEnableMem(writeEnableMem), .o_readEnableMem(readEnableMem),
    .o_burstLength(burstLength), .o_dataMem(dataToMem),
    .o_targetAddr(memAddr), .o_byteEnableMem(byteEnableMem)
  );

  tbMemModel memModel_inst (
    .i_clk(clk), .i_rst(rst),
    .i_writeEnableMem(writeEnableMem), .i_readEnableMem(readEnableMem),
    .i_burstLength(burstLength), .i_dataMem(dataToMem), .i_targetAddr(memAddr),
    .i_byteEnableMem(byteEnableMem),
    .o_busyMem(busyMem), .o_dataValidMem(dataValidMem), .o_dataMem(dataFromMem)
  );

  tbChecker checker_inst (
    .i_clk(clk), .i_rst(rst),
    .i_busyClient(busyClient), .i_dataValidClient(dataValidClient),
    .i_dataClient(dataToClient), .i_writeEnableMem(writeEnableMem),
    .i_readEnableMem(readEnableMem), .i_burstLength(burstLength),
    .i_dataMem(dataToMem), .i_targetAddr(memAddr), .i_byteEnableMem(byteEnableMem),
    .i_busyMem(busyMem),
    .i_expWrite(expWrite), .i_expSize(expSize), .i_expAddr(expAddr),
    .i_expMask(expMask), .i_expData(expData), .i_expRead(expRead),
    .i_numTests(numTests), .o_testsDone(testsDone), .o_errors(errors)
  );

  initial begin
    $readmemh("tb_input.txt", vec);
    numTests = int'(vec[0]);
    while (!rst) @(negedge clk);
    for (int t = 0; t < numTests; t++) begin
      base = 1 + 7 * t;
      while (busyClient) @(negedge clk);
      @(posedge clk);
      command       <= 1'b1;
      writeElseRead <= vec[base][0];
      commandSize   <= vec[base+1][1:0];
      targetAddr    <= vec[base+2][14:0];
      subAddr       <= vec[base+3][2:0];
      writeMask     <= vec[base+4][15:0];
      dataClient    <= vec[base+5];
      expWrite      <= vec[base][0];
      expSize       <= vec[base+1][1:0];
      expAddr       <= {8'd0, vec[base+2][14:0], vec[base+3][2:0]};
      expMask       <= vec[base+4][15:0];
      expData       <= vec[base+5];
      expRead       <= vec[base+6];
      @(posedge clk);
      command <= 1'b0;
      // Long bursts get a stray command while busy
      if (vec[base+1][1]) begin
        @(posedge clk);
        command       <= 1'b1;
        writeElseRead <= ~vec[base][0];
        dataClient    <= ~vec[base+5];
        @(posedge clk);
        command <= 1'b0;
      end
      while (testsDone < t + 1) @(negedge clk);
    end
    // A few idle cycles catch stray strobes after the last request
    repeat (2) @(negedge clk);
    if (errors == 0 && numTests > 0 && testsDone == numTests) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the test count
  initial begin
    wait (numTests > 0);
    repeat (numTests * 200) @(posedge clk);
    $display("Timeout, the tests did not finish in time");
    $display("Test failed");
    $finish;
  end

endmodule

// ==== tbChecker.sv ====
`timescale 1ns/1ps

module tbChecker (
  input  logic         i_clk,
  input  logic         i_rst,
  input  logic         i_busyClient,
  input  logic         i_dataValidClient,
  input  logic [255:0] i_dataClient,
  input  logic         i_writeEnableMem,
  input  logic         i_readEnableMem,
  input  logic [7:0]   i_burstLength,
  input  logic [31:0]  i_dataMem,
  input  logic [25:0]  i_targetAddr,
  input  logic [3:0]   i_byteEnableMem,
  input  logic         i_busyMem,
  input  logic         i_expWrite,
  input  logic [1:0]   i_expSize,
  input  logic [25:0]  i_expAddr,
  input  logic [15:0]  i_expMask,
  input  logic [255:0] i_expData,
  input  logic [255:0] i_expRead,
  input  int           i_numTests,
  output int           o_testsDone,
  output int           o_errors
);

  int   beatCount = 0;
  int   stallCount = 0;
  int   busyCycles = 0;
  int   validCount = 0;
  int   testErrors = 0;
  int   passCount = 0;
  int   failCount = 0;
  int   doneCount = 0;
  int   errorTotal = 0;
  logic busyPrev = 1'b0;
  logic resetChecked = 1'b0;

  assign o_testsDone = doneCount;
  assign o_errors    = errorTotal + testErrors;

  function automatic int burstBeats(input logic [1:0] size);
    case (size)
      2'd0:    return 1;
      2'd1:    return 2;
      default: return 8;
    endcase
  endfunction

  // Two byte lanes per mask bit
  function automatic logic [3:0] beatEnables(input int k);
    return {i_expMask[2*k+1], i_expMask[2*k+1], i_expMask[2*k], i_expMask[2*k]};
  endfunction

  task automatic compareValue(input string name, input logic [255:0] expected,
                              input logic [255:0] got);
    if (expected !== got) begin
      $display("** Error %s: expected %h, got %h", name, expected, got);
      testErrors++;
    end
  endtask

  task automatic compareCount(input string what, input int expected, input int got);
    if (expected != got) begin
      $display("Wrong number of %s: expected %0d, counted %0d", what, expected, got);
      testErrors++;
    end
  endtask

  task automatic noteFailure(input string msg);
    $display("%s", msg);
    testErrors++;
  endtask

  task automatic closeTest();
    int len;
    len = burstBeats(i_expSize);
    if (i_expWrite) begin
      compareCount("write beats", len, beatCount);
      compareCount("busy cycles", len + stallCount, busyCycles);
      compareCount("read valid pulses", 0, validCount);
    end else begin
      compareCount("read valid pulses", 1, validCount);
      compareCount("write beats", 0, beatCount);
    end
    doneCount++;
    $display("Test %0d: %s of %0d beats %s", doneCount, i_expWrite ? "write" : "read",
             len, (testErrors == 0) ? "passed" : "FAILED");
    if (testErrors == 0) passCount++;
    else failCount++;
    errorTotal += testErrors;
    testErrors = 0;
    beatCount = 0;
    stallCount = 0;
    busyCycles = 0;
    validCount = 0;
    if (doneCount == i_numTests) begin
      $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
               doneCount, passCount, failCount, errorTotal);
    end
  endtask

  always @(posedge i_clk) begin
    if (i_rst) begin
      if (!resetChecked) begin
        compareValue("o_busyClient", 0, i_busyClient);
        compareValue("o_writeEnableMem", 0, i_writeEnableMem);
        compareValue("o_readEnableMem", 0, i_readEnableMem);
        compareValue("o_dataValidClient", 0, i_dataValidClient);
        compareValue("o_dataClient", 0, i_dataClient);
        $display("Reset check %s", (testErrors == 0) ? "passed" : "FAILED");
        errorTotal += testErrors;
        testErrors = 0;
        resetChecked = 1'b1;
      end
      if (i_busyClient) busyCycles++;
      if (i_writeEnableMem) begin
        if (!i_expWrite) noteFailure("Write enable raised during a read request");
        compareValue("o_targetAddr", i_expAddr, i_targetAddr);
        compareValue("o_burstLength", burstBeats(i_expSize), i_burstLength);
        if (i_busyMem) begin
          stallCount++;
        end else begin
          if (beatCount >= burstBeats(i_expSize)) begin
            noteFailure("Write beat sent past the end of the burst");
          end else begin
            compareValue("o_dataMem", i_expData[32*beatCount +: 32], i_dataMem);
            compareValue("o_byteEnableMem", beatEnables(beatCount), i_byteEnableMem);
          end
          beatCount++;
        end
      end else begin
        // Every byte lane stays enabled outside a write
        compareValue("o_byteEnableMem", 4'hF, i_byteEnableMem);
      end
      if (i_readEnableMem) begin
        if (i_expWrite) noteFailure("Read enable raised during a write request");
        compareValue("o_targetAddr", i_expAddr, i_targetAddr);
        compareValue("o_burstLength", burstBeats(i_expSize), i_burstLength);
      end
      if (i_dataValidClient) begin
        validCount++;
        compareValue("o_dataClient", i_expRead, i_dataClient);
      end
      if (busyPrev && !i_busyClient) closeTest();
      busyPrev = i_busyClient;
    end
  end

endmodule

// ==== tbMemModel.sv ====
`timescale 1ns/1ps

module tbMemModel (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_writeEnableMem,
  input  logic        i_readEnableMem,
  input  logic [7:0]  i_burstLength,
  input  logic [31:0] i_dataMem,
  input  logic [25:0] i_targetAddr,
  input  logic [3:0]  i_byteEnableMem,
  output logic        o_busyMem,
  output logic        o_dataValidMem,
  output logic [31:0] o_dataMem
);

  logic [31:0] mem [0:255];
  logic [31:0] seed;
  logic [25:0] readAddr;
  logic [7:0]  readLen;
  logic [7:0]  idx;
  logic        readActive;
  int          writeCount;
  int          readCount;
  int          readWait;

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Each word starts out tagged with its own address
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] <= 32'hA5A5_0000 | i;
    end
  end

  always @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      o_busyMem      <= 1'b0;
      o_dataValidMem <= 1'b0;
      o_dataMem      <= '0;
      seed = 32'd60353;
      writeCount = 0;
      readActive = 1'b0;
    end else begin
      seed = nextRandom(seed);
      o_busyMem      <= (seed[17:16] == 2'b00);
      o_dataValidMem <= 1'b0;
      // Write beats land byte by byte
      if (i_writeEnableMem && !o_busyMem) begin
        idx = i_targetAddr[7:0] + writeCount[7:0];
        for (int b = 0; b < 4; b++) begin
          if (i_byteEnableMem[b]) begin
            mem[idx][8*b +: 8] <= i_dataMem[8*b +: 8];
          end
        end
        writeCount++;
      end else if (!i_writeEnableMem) begin
        writeCount = 0;
      end
      // Read queued, then streamed after 1 to 4 cycles
      if (i_readEnableMem && !o_busyMem && !readActive) begin
        readActive = 1'b1;
        readAddr = i_targetAddr;
        readLen = i_burstLength;
        readWait = seed[23:22];
        readCount = 0;
      end else if (readActive) begin
        if (readWait != 0) begin
          readWait--;
        end else begin
          idx = readAddr[7:0] + readCount[7:0];
          o_dataValidMem <= 1'b1;
          o_dataMem      <= mem[idx];
          readCount++;
          if (readCount == readLen) begin
            readActive = 1'b0;
          end
        end
      end
    end
  end

endmodule

// ==== tbClockGen.sv ====
`timescale 1ns/1ps

module tbClockGen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // Reset held low for the first eight cycles
  initial begin
    o_rst = 1'b0;
    repeat (8) @(posedge o_clk);
    o_rst <= 1'b1;
  end

endmodule

// ==== psxDdrBridge.sv ====
`timescale 1ns/1ps
`include "ddrBridge_defines.svh"

module psxDdrBridge (
  input  logic                       i_clk,
  input  logic                       i_rst,

  // Client side
  input  logic                       i_command,
  input  logic                       i_writeElseRead,
  input  logic [1:0]                 i_commandSize,
  input  logic [14:0]                i_targetAddr,
  input  logic [2:0]                 i_subAddr,
  input  logic [`MASK_W-1:0]         i_writeMask,
  input  logic [`CLIENT_DATA_W-1:0]  i_dataClient,
  output logic                       o_busyClient,
  output logic                       o_dataValidClient,
  output logic [`CLIENT_DATA_W-1:0]  o_dataClient,

  // Memory side
  input  logic                       i_busyMem,
  input  logic                       i_dataValidMem,
  input  logic [`DDR_DATA_W-1:0]     i_dataMem,
  output logic                       o_writeEnableMem,
  output logic                       o_readEnableMem,
  output logic [`BURST_W-1:0]        o_burstLength,
  output logic [`DDR_DATA_W-1:0]     o_dataMem,
  output logic [`MEM_ADDR_W-1:0]     o_targetAddr,
  output logic [(`DDR_DATA_W/8)-1:0] o_byteEnableMem
);
  import ddrBridgePkg::*;

  burstCtrlIf ctrlBus ();

  burstController burstController_inst (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_command        (i_command),
    .i_writeElseRead  (i_writeElseRead),
    .i_commandSize    (cmdSize_e'(i_commandSize)),
    .i_targetAddr     (i_targetAddr),
    .i_subAddr        (i_subAddr),
    .i_busyMem        (i_busyMem),
    .i_dataValidMem   (i_dataValidMem),
    .o_busyClient     (o_busyClient),
    .o_writeEnableMem (o_writeEnableMem),
    .o_readEnableMem  (o_readEnableMem),
    .o_burstLength    (o_burstLength),
    .o_targetAddr     (o_targetAddr),
    .ctrlBus          (ctrlBus.ctrl)
  );

  writeSerializer writeSerializer_inst (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_dataClient    (i_dataClient),
    .i_writeMask     (i_writeMask),
    .ctrlBus         (ctrlBus.data),
    .o_dataMem       (o_dataMem),
    .o_byteEnableMem (o_byteEnableMem)
  );

  readAssembler readAssembler_inst (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_dataMem         (i_dataMem),
    .ctrlBus           (ctrlBus.data),
    .o_dataClient      (o_dataClient),
    .o_dataValidClient (o_dataValidClient)
  );

endmodule

// ==== readAssembler.sv ====
`timescale 1ns/1ps
`include "ddrBridge_defines.svh"

module readAssembler (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic [`DDR_DATA_W-1:0]    i_dataMem,
  burstCtrlIf.data                  ctrlBus,
  output logic [`CLIENT_DATA_W-1:0] o_dataClient,
  output logic                      o_dataValidClient
);

  localparam int BEATS = `CLIENT_DATA_W / `DDR_DATA_W;
  localparam int SEL_W = $clog2(BEATS);

  logic [BEATS-1:0][`DDR_DATA_W-1:0] wordBeats;
  logic [SEL_W-1:0]                  beatSel;

  assign beatSel = ctrlBus.beatIdx[SEL_W-1:0];

  // Beats land at their own position, unfilled beats stay zero
  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      wordBeats <= '0;
    end else if (ctrlBus.accept) begin
      wordBeats <= '0;
    end else if (ctrlBus.readBeat) begin
      wordBeats[beatSel] <= i_dataMem;
    end
  end

  // One-cycle completion strobe after the final beat
  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      o_dataValidClient <= 1'b0;
    end else begin
      o_dataValidClient <= ctrlBus.readBeat && ctrlBus.lastBeat;
    end
  end

  assign o_dataClient = wordBeats;

endmodule

// ==== writeSerializer.sv ====
`timescale 1ns/1ps
`include "ddrBridge_defines.svh"

module writeSerializer (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic [`CLIENT_DATA_W-1:0]   i_dataClient,
  input  logic [`MASK_W-1:0]          i_writeMask,
  burstCtrlIf.data                    ctrlBus,
  output logic [`DDR_DATA_W-1:0]      o_dataMem,
  output logic [(`DDR_DATA_W/8)-1:0]  o_byteEnableMem
);

  localparam int BEATS = `CLIENT_DATA_W / `DDR_DATA_W;
  localparam int SEL_W = $clog2(BEATS);

  logic [BEATS-1:0][`DDR_DATA_W-1:0] dataBeats;
  // Two half-word enables per beat
  logic [BEATS-1:0][1:0]             maskPairs;
  logic [SEL_W-1:0]                  beatSel;
  logic [1:0]                        halfEn;

  assign beatSel = ctrlBus.beatIdx[SEL_W-1:0];
  assign halfEn  = maskPairs[beatSel];

  // Client word captured once per request
  always_ff @(posedge i_clk) begin
    if (ctrlBus.accept) begin
      dataBeats <= i_dataClient;
    end
  end

  // Mask returns to all enabled once a burst ends
  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      maskPairs <= '1;
    end else if (ctrlBus.accept) begin
      maskPairs <= i_writeMask;
    end else if ((ctrlBus.writeBeat || ctrlBus.readBeat) && ctrlBus.lastBeat) begin
      maskPairs <= '1;
    end
  end

  assign o_dataMem = dataBeats[beatSel];

  // Reads always use every byte lane
  always_comb begin
    if (ctrlBus.inRead) begin
      o_byteEnableMem = '1;
    end else begin
      o_byteEnableMem = {halfEn[1], halfEn[1], halfEn[0], halfEn[0]};
    end
  end

endmodule

// ==== burstController.sv ====
`timescale 1ns/1ps
`include "ddrBridge_defines.svh"

module burstController (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_command,
  input  logic                   i_writeElseRead,
  input  ddrBridgePkg::cmdSize_e i_commandSize,
  input  logic [14:0]            i_targetAddr,
  input  logic [2:0]             i_subAddr,
  input  logic                   i_busyMem,
  input  logic                   i_dataValidMem,
  output logic                   o_busyClient,
  output logic                   o_writeEnableMem,
  output logic                   o_readEnableMem,
  output logic [`BURST_W-1:0]    o_burstLength,
  output logic [`MEM_ADDR_W-1:0] o_targetAddr,
  burstCtrlIf.ctrl               ctrlBus
);
  import ddrBridgePkg::*;

  bridgeState_e state;
  beatIdx_t     beatIdx;
  beatIdx_t     sizeLen;

  // Beats needed for the requested size
  always_comb begin
    case (i_commandSize)
      DOUBLE_WORD:             sizeLen = `DW_BURST_LEN;
      QUAD_WORD:               sizeLen = `QW_BURST_LEN;
      BIG_WORD, RESERVED_WORD: sizeLen = `BIG_BURST_LEN;
      default:                 sizeLen = `BIG_BURST_LEN;
    endcase
  end

  // Strobes to the datapaths
  assign ctrlBus.accept    = (state == WAIT_CMD) && i_command;
  assign ctrlBus.writeBeat = (state == WRITE_BURST) && !i_busyMem;
  assign ctrlBus.readBeat  = (state == READ_BURST) && i_dataValidMem;
  assign ctrlBus.lastBeat  = (beatIdx == o_burstLength - 1'b1);
  assign ctrlBus.inRead    = (state == READ_REQUEST) || (state == READ_BURST);
  assign ctrlBus.beatIdx   = beatIdx;

  assign o_busyClient     = (state != WAIT_CMD);
  assign o_writeEnableMem = (state == WRITE_BURST);
  assign o_readEnableMem  = (state == READ_REQUEST);

  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      state         <= WAIT_CMD;
      o_burstLength <= `DW_BURST_LEN;
      o_targetAddr  <= '0;
    end else begin
      case (state)
        WAIT_CMD: begin
          if (ctrlBus.accept) begin
            // Hold request parameters for the whole burst
            o_burstLength <= sizeLen;
            o_targetAddr  <= {{(`MEM_ADDR_W - 18){1'b0}}, i_targetAddr, i_subAddr};
            if (i_writeElseRead) begin
              state <= WRITE_BURST;
            end else begin
              state <= READ_REQUEST;
            end
          end
        end
        WRITE_BURST: begin
          if (ctrlBus.writeBeat && ctrlBus.lastBeat) begin
            state <= WAIT_CMD;
          end
        end
        READ_REQUEST: begin
          // Memory queues the read once it is not busy
          if (!i_busyMem) begin
            state <= READ_BURST;
          end
        end
        READ_BURST: begin
          if (ctrlBus.readBeat && ctrlBus.lastBeat) begin
            state <= WAIT_CMD;
          end
        end
        default: begin
          state <= WAIT_CMD;
        end
      endcase
    end
  end

  // Beat counter, held while memory stalls
  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      beatIdx <= '0;
    end else if (ctrlBus.accept) begin
      beatIdx <= '0;
    end else if (ctrlBus.writeBeat || ctrlBus.readBeat) begin
      if (ctrlBus.lastBeat) begin
        beatIdx <= '0;
      end else begin
        beatIdx <= beatIdx + 1'b1;
      end
    end
  end

endmodule

// ==== burstCtrlIf.sv ====
`timescale 1ns/1ps

interface burstCtrlIf;
  import ddrBridgePkg::*;

  // Command taken this cycle
  logic     accept;
  // Beat currently on the memory port
  beatIdx_t beatIdx;
  // Memory took a write beat
  logic     writeBeat;
  // A read beat arrived
  logic     readBeat;
  // Current beat closes the burst
  logic     lastBeat;
  // Read request or read burst in progress
  logic     inRead;

  modport ctrl (
    output accept, beatIdx, writeBeat, readBeat, lastBeat, inRead
  );

  modport data (
    input accept, beatIdx, writeBeat, readBeat, lastBeat, inRead
  );

endinterface

// ==== ddrBridgePkg.sv ====
`include "ddrBridge_defines.svh"

package ddrBridgePkg;

  // Client request size
  typedef enum logic [1:0] {
    DOUBLE_WORD   = 2'b00,
    QUAD_WORD     = 2'b01,
    BIG_WORD      = 2'b10,
    // Unused code, served as a 256-bit request
    RESERVED_WORD = 2'b11
  } cmdSize_e;

  // Bridge sequencing states
  typedef enum logic [1:0] {
    WAIT_CMD     = 2'b00,
    WRITE_BURST  = 2'b01,
    READ_REQUEST = 2'b10,
    READ_BURST   = 2'b11
  } bridgeState_e;

  // Index of the beat inside a burst
  typedef logic [`BURST_W-1:0] beatIdx_t;

endpackage

// ==== ddrBridge_defines.svh ====
`ifndef DDRBRIDGE_DEFINES_SVH
`define DDRBRIDGE_DEFINES_SVH

// Memory side beat width
`define DDR_DATA_W 32

// Client side word and half-word mask
`define CLIENT_DATA_W 256
`define MASK_W 16

// Memory address width
`define MEM_ADDR_W 26

// Burst length port and beat counter width
`define BURST_W 8

// Beats per request size
`define BIG_BURST_LEN 8'd8
`define QW_BURST_LEN 8'd2
`define DW_BURST_LEN 8'd1

`endif
